// File: include/frontend_params.svh
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

////////////////////////////////////////
// Fetch front end sizing
////////////////////////////////////////

// First fetch address after reset, pair aligned
`define FE_RESET_PC 32'h1c00_0000

// Instruction buffer entries
// Must be a power of two for pointer wrap
`define FE_BUF_DEPTH 16

// Two-bit counter table entries
// Indexed by pc bits above the word offset
`define FE_CNT_ENTRIES 64

`endif

// File: source/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // Address and instruction words
    ////////////////////////////////////////

    // Byte address
    typedef logic [31:0] addr_t;

    // One instruction word
    typedef logic [31:0] inst_t;

    ////////////////////////////////////////
    // Buffer slot
    ////////////////////////////////////////

    // One predicted instruction as the back end sees it
    // pred_target is the predicted next pc, pc+4 when not taken
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  pred_taken;
        addr_t pred_target;
    } slot_t;

endpackage

// File: source/predict_pkg.sv
`include "frontend_params.svh"

package predict_pkg;

    ////////////////////////////////////////
    // Predecode
    ////////////////////////////////////////

    // Major opcode in inst[31:26]
    // Any encoding not listed decodes as OP_OTHER
    typedef enum logic [5:0] {
        OP_OTHER  = 6'b000000,
        OP_JUMP   = 6'b000010,
        OP_BRANCH = 6'b000100
    } opcode_e;

    ////////////////////////////////////////
    // Counter table
    ////////////////////////////////////////

    // Saturating counter, WEAK_T and above predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } counter_e;

    // Table index taken from pc, used for lookup and for upd_pc
    typedef logic [$clog2(`FE_CNT_ENTRIES)-1:0] cnt_idx_t;

endpackage

// File: source/pc_gen.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module pc_gen (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             icache_stall,
    input  logic             almost_full,
    input  logic             flush,
    input  fetch_pkg::addr_t new_pc,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    output logic             fetch_req,
    output fetch_pkg::addr_t fetch_pc
);
    import fetch_pkg::*;

    logic  run_q;
    addr_t pc_next;

    ////////////////////////////////////////
    // Request generation
    ////////////////////////////////////////

    // Held off for one cycle out of reset
    // Cache stall and a nearly full buffer both stop new pairs
    assign fetch_req = run_q && !icache_stall && !almost_full;

    ////////////////////////////////////////
    // Next fetch address
    ////////////////////////////////////////

    // Flush wins over redirect, redirect wins over sequential
    // Redirects are taken even while stalled so the strobe is not lost
    always_comb begin
        if (flush) begin
            pc_next = new_pc;
        end else if (redirect) begin
            // Fetch the pair holding the target, predictor skips slot 0 if needed
            pc_next = {redirect_pc[31:3], 3'b000};
        end else if (fetch_req) begin
            pc_next = fetch_pc + 32'd8;
        end else begin
            pc_next = fetch_pc;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q    <= 1'b0;
            fetch_pc <= `FE_RESET_PC;
        end else begin
            run_q    <= 1'b1;
            fetch_pc <= pc_next;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Back end restarts on pair boundaries, so every fetch stays aligned
    a_fetch_pc_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        fetch_pc[2:0] == 3'b000
    ) else $error("fetch_pc %h is not pair aligned", fetch_pc);

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             resp_valid,
    input  fetch_pkg::addr_t resp_pc,
    input  fetch_pkg::inst_t resp_inst [2],
    input  logic             flush,
    input  logic             upd_valid,
    input  fetch_pkg::addr_t upd_pc,
    input  logic             upd_taken,
    output logic             redirect,
    output fetch_pkg::addr_t redirect_pc,
    output logic             wr_valid [2],
    output fetch_pkg::slot_t wr_slot [2]
);
    import fetch_pkg::*;
    import predict_pkg::*;

    localparam int IDX_W = $bits(cnt_idx_t);

    counter_e cnt_table [`FE_CNT_ENTRIES];
    cnt_idx_t upd_idx;
    logic     squash_q;
    logic     skip_q;
    logic     live;
    logic     slot_ok [2];
    logic     taken [2];
    addr_t    target [2];
    slot_t    slot [2];

    function automatic opcode_e decode_op(input inst_t inst);
        case (inst[31:26])
            OP_JUMP:   return OP_JUMP;
            OP_BRANCH: return OP_BRANCH;
            default:   return OP_OTHER;
        endcase
    endfunction

    function automatic counter_e next_count(input counter_e cnt, input logic outcome);
        if (outcome) begin
            return (cnt == STRONG_T) ? STRONG_T : counter_e'(cnt + 2'd1);
        end
        return (cnt == STRONG_NT) ? STRONG_NT : counter_e'(cnt - 2'd1);
    endfunction

    ////////////////////////////////////////
    // Predecode, one per slot
    ////////////////////////////////////////

    for (genvar i = 0; i < 2; i++) begin : g_slot
        addr_t    pc;
        opcode_e  op;
        cnt_idx_t idx;
        addr_t    offset;

        assign pc  = resp_pc + 32'(i * 4);
        assign op  = decode_op(resp_inst[i]);
        assign idx = pc[IDX_W+1:2];

        // Sign extended word offsets
        always_comb begin
            case (op)
                OP_JUMP:   offset = {{4{resp_inst[i][25]}}, resp_inst[i][25:0], 2'b00};
                OP_BRANCH: offset = {{14{resp_inst[i][15]}}, resp_inst[i][15:0], 2'b00};
                default:   offset = 32'd4;
            endcase
        end

        assign taken[i]  = (op == OP_JUMP) || (op == OP_BRANCH && cnt_table[idx] >= WEAK_T);
        assign target[i] = taken[i] ? pc + offset : pc + 32'd4;
        assign slot[i]   = '{
            inst:        resp_inst[i],
            pc:          pc,
            pred_taken:  taken[i],
            pred_target: target[i]
        };
    end

    ////////////////////////////////////////
    // Slot selection and redirect
    ////////////////////////////////////////

    assign live       = resp_valid && !squash_q && !flush;
    assign slot_ok[0] = live && !skip_q;
    // Nothing after a taken slot 0
    assign slot_ok[1] = live && !(slot_ok[0] && taken[0]);

    assign redirect    = (slot_ok[0] && taken[0]) || (slot_ok[1] && taken[1]);
    assign redirect_pc = (slot_ok[0] && taken[0]) ? target[0] : target[1];

    // Packed toward slot 0 so the buffer never sees a lone slot 1
    assign wr_valid[0] = slot_ok[0] || slot_ok[1];
    assign wr_valid[1] = slot_ok[0] && slot_ok[1];
    assign wr_slot[0]  = slot_ok[0] ? slot[0] : slot[1];
    assign wr_slot[1]  = slot[1];

    // One stale pair is in flight after a redirect or a flush
    // skip_q drops slot 0 of the first live pair when the target is at pc+4
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            squash_q <= 1'b0;
            skip_q   <= 1'b0;
        end else begin
            squash_q <= redirect || flush;
            if (flush) begin
                skip_q <= 1'b0;
            end else if (redirect) begin
                skip_q <= redirect_pc[2];
            end else if (live) begin
                skip_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Counter training
    ////////////////////////////////////////

    assign upd_idx = upd_pc[IDX_W+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `FE_CNT_ENTRIES; i++) begin
                cnt_table[i] <= WEAK_NT;
            end
        end else if (upd_valid) begin
            cnt_table[upd_idx] <= next_count(cnt_table[upd_idx], upd_taken);
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_redirect_has_resp : assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect |-> resp_valid
    ) else $error("redirect without a cache response");

endmodule

// File: source/inst_buffer.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module inst_buffer (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             pause,
    input  logic             send_en,
    input  logic             wr_valid [2],
    input  fetch_pkg::slot_t wr_slot [2],
    output logic             almost_full,
    output logic             out_valid [2],
    output fetch_pkg::slot_t out_slot [2]
);
    import fetch_pkg::*;

    localparam int DEPTH = `FE_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    slot_t            mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [1:0]       n_wr;
    logic [1:0]       n_rd;
    logic             retire;

    ////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////

    assign n_wr   = 2'(wr_valid[0]) + 2'(wr_valid[1]);
    assign retire = send_en && !pause;
    assign n_rd   = retire ? 2'(out_valid[0]) + 2'(out_valid[1]) : 2'd0;

    // Room for two pairs still in flight
    assign almost_full = (CNT_W'(DEPTH) - count) < CNT_W'(4);

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // Oldest two entries
    assign out_valid[0] = count != '0;
    assign out_valid[1] = count > CNT_W'(1);
    assign out_slot[0]  = mem[rd_ptr];
    assign out_slot[1]  = mem[rd_ptr + PTR_W'(1)];

    ////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_valid[0] && !flush) begin
            mem[wr_ptr] <= wr_slot[0];
        end
        if (wr_valid[1] && !flush) begin
            mem[wr_ptr + PTR_W'(1)] <= wr_slot[1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // Drop everything, including this cycle's retire
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(n_rd);
            wr_ptr <= wr_ptr + PTR_W'(n_wr);
            count  <= count + CNT_W'(n_wr) - CNT_W'(n_rd);
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Holds only if pc_gen honours almost_full with two pairs in flight
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!arst_n)
        !flush |-> (count + CNT_W'(n_wr)) <= CNT_W'(DEPTH)
    ) else $error("instruction buffer written past full");

    a_out_order : assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid[1] |-> out_valid[0]
    ) else $error("out_valid[1] without out_valid[0]");

endmodule

// File: source/frontend_top.sv
`timescale 1ns/100ps

module frontend_top (
    input  logic             clk,
    input  logic             arst_n,
    // Instruction cache
    output logic             fetch_req,
    output fetch_pkg::addr_t fetch_pc,
    input  logic             icache_stall,
    input  logic             resp_valid,
    input  fetch_pkg::addr_t resp_pc,
    input  fetch_pkg::inst_t resp_inst [2],
    // Back end
    input  logic             flush,
    input  fetch_pkg::addr_t new_pc,
    input  logic             pause,
    input  logic             send_en,
    input  logic             upd_valid,
    input  fetch_pkg::addr_t upd_pc,
    input  logic             upd_taken,
    output logic             out_valid [2],
    output fetch_pkg::slot_t out_slot [2]
);
    import fetch_pkg::*;

    logic  redirect;
    addr_t redirect_pc;
    logic  wr_valid [2];
    slot_t wr_slot [2];
    logic  almost_full;

    pc_gen u_pc_gen (
        .clk          (clk),
        .arst_n       (arst_n),
        .icache_stall (icache_stall),
        .almost_full  (almost_full),
        .flush        (flush),
        .new_pc       (new_pc),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc)
    );

    branch_predictor u_branch_predictor (
        .clk          (clk),
        .arst_n       (arst_n),
        .resp_valid   (resp_valid),
        .resp_pc      (resp_pc),
        .resp_inst    (resp_inst),
        .flush        (flush),
        .upd_valid    (upd_valid),
        .upd_pc       (upd_pc),
        .upd_taken    (upd_taken),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .wr_valid     (wr_valid),
        .wr_slot      (wr_slot)
    );

    inst_buffer u_inst_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .pause        (pause),
        .send_en      (send_en),
        .wr_valid     (wr_valid),
        .wr_slot      (wr_slot),
        .almost_full  (almost_full),
        .out_valid    (out_valid),
        .out_slot     (out_slot)
    );

endmodule

// File: bench/tb_frontend.sv
`timescale 1ns/100ps
`include "frontend_params.svh"

module tb_frontend #(parameter int SEED = 41471);
    import fetch_pkg::*;
    import predict_pkg::*;

    localparam int TIMEOUT = 200;

    logic     clk;
    logic     arst_n;
    logic     fetch_req;
    addr_t    fetch_pc;
    logic     icache_stall;
    logic     resp_valid;
    addr_t    resp_pc;
    inst_t    resp_inst [2];
    logic     flush;
    addr_t    new_pc;
    logic     pause;
    logic     send_en;
    logic     upd_valid;
    addr_t    upd_pc;
    logic     upd_taken;
    logic     out_valid [2];
    slot_t    out_slot [2];
    logic     stall_en;
    inst_t    prog [addr_t];
    counter_e ref_cnt [`FE_CNT_ENTRIES];
    slot_t    got_q [$];

    frontend_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////
    // Cache model and output monitor
    ////////////////////////////////////////

    // OP_OTHER filler with the address folded into the low bits
    function automatic inst_t prog_word(input addr_t a);
        if (prog.exists(a)) begin
            return prog[a];
        end
        return {6'b000001, a[27:2] ^ {22'd0, a[31:28]}};
    endfunction

    // Request seen at negedge is accepted at the next posedge
    initial begin : cache_model
        logic  req_seen;
        addr_t req_pc;
        forever begin
            @(negedge clk);
            req_seen = fetch_req && arst_n;
            req_pc   = fetch_pc;
            @(posedge clk);
            #1;
            resp_valid   = req_seen;
            resp_pc      = req_pc;
            resp_inst[0] = prog_word(req_pc);
            resp_inst[1] = prog_word(req_pc + 32'd4);
            icache_stall = stall_en && ($urandom % 3 == 0);
        end
    end

    always @(negedge clk) begin
        if (arst_n && send_en && !pause) begin
            if (out_valid[0]) begin
                got_q.push_back(out_slot[0]);
            end
            if (out_valid[1]) begin
                got_q.push_back(out_slot[1]);
            end
        end
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic inst_t encode(input opcode_e op, input addr_t pc, input addr_t target);
        addr_t diff;
        diff = target - pc;
        if (op == OP_JUMP) begin
            return {OP_JUMP, diff[27:2]};
        end
        return {OP_BRANCH, 10'd0, diff[17:2]};
    endfunction

    // Expected slot from the opcode, offset and counter rules
    function automatic slot_t ref_slot(input addr_t pc);
        inst_t inst;
        logic  taken;
        addr_t offset;
        inst   = prog_word(pc);
        taken  = 1'b0;
        offset = 32'd4;
        if (inst[31:26] == OP_JUMP) begin
            taken  = 1'b1;
            offset = 32'($signed(inst[25:0])) << 2;
        end else if (inst[31:26] == OP_BRANCH && ref_cnt[cnt_idx_t'(pc >> 2)] >= WEAK_T) begin
            taken  = 1'b1;
            offset = 32'($signed(inst[15:0])) << 2;
        end
        return '{inst: inst, pc: pc, pred_taken: taken, pred_target: pc + offset};
    endfunction

    ////////////////////////////////////////
    // Compare and helper tasks
    ////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_slot(input string name, input slot_t exp, input slot_t act);
        if (act !== exp) begin
            abort_run($sformatf(
                {"ERROR %s: expected pc=%h inst=%h taken=%b target=%h, ",
                 "actual pc=%h inst=%h taken=%b target=%h"},
                name, exp.pc, exp.inst, exp.pred_taken, exp.pred_target,
                act.pc, act.inst, act.pred_taken, act.pred_target));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected pc %h, actual pc %h", name, exp, act));
        end
    endtask

    task automatic check_counter(input string name, input counter_e exp, input counter_e act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s: expected counter %s, actual counter %s",
                name, exp.name(), act.name()));
        end
    endtask

    // Back end holds pause over the flush cycle so nothing old is taken
    task automatic flush_to(input addr_t pc, input logic hold_pause);
        @(posedge clk);
        #1;
        flush  = 1'b1;
        new_pc = pc;
        pause  = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        pause = hold_pause;
        got_q.delete();
    endtask

    task automatic train(input string name, input addr_t pc, input logic taken);
        cnt_idx_t idx;
        idx = cnt_idx_t'(pc >> 2);
        @(posedge clk);
        #1;
        upd_valid = 1'b1;
        upd_pc    = pc;
        upd_taken = taken;
        @(posedge clk);
        #1;
        upd_valid = 1'b0;
        case (ref_cnt[idx])
            STRONG_NT: ref_cnt[idx] = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   ref_cnt[idx] = taken ? WEAK_T : STRONG_NT;
            WEAK_T:    ref_cnt[idx] = taken ? STRONG_T : WEAK_NT;
            default:   ref_cnt[idx] = taken ? STRONG_T : WEAK_T;
        endcase
        check_counter(name, ref_cnt[idx], dut.u_branch_predictor.cnt_table[idx]);
    endtask

    // Walks the predicted path and compares every delivered slot
    task automatic expect_stream(input string name, input addr_t start_pc, input int n);
        addr_t pc;
        slot_t exp;
        slot_t act;
        int    waited;
        pc = start_pc;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            while (got_q.size() == 0) begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("%s: no instruction delivered in time", name));
                end
            end
            act = got_q.pop_front();
            exp = ref_slot(pc);
            check_addr(name, exp.pc, act.pc);
            check_slot(name, exp, act);
            pc = exp.pred_target;
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic flush_test();
        int waited;
        @(posedge clk);
        #1;
        send_en = 1'b0;
        waited  = 0;
        // Let the buffer collect old work before it is thrown away
        while (!(out_valid[0] && out_valid[1])) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("buffer never filled before flush");
            end
        end
        flush_to(32'h1c00_3000, 1'b0);
        send_en = 1'b1;
        expect_stream("flush", 32'h1c00_3000, 16);
    endtask

    task automatic backpressure_test();
        int waited;
        stall_en = 1'b1;
        flush_to(32'h1c00_4000, 1'b1);
        waited = 0;
        while (!dut.almost_full) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("buffer never reached almost full while paused");
            end
        end
        repeat (6) begin
            @(negedge clk);
            if (fetch_req) begin
                abort_run("fetch request issued while the buffer was nearly full");
            end
            // Paused outputs keep the oldest entry in place
            check_addr("backpressure hold", 32'h1c00_4000, out_slot[0].pc);
        end
        @(posedge clk);
        #1;
        pause = 1'b0;
        expect_stream("backpressure", 32'h1c00_4000, 48);
        stall_en = 1'b0;
    endtask

    task automatic branch_training_test();
        addr_t br;
        br = 32'h1c00_2004;
        flush_to(32'h1c00_2000, 1'b0);
        expect_stream("branch untrained", 32'h1c00_2000, 8);
        train("branch train taken", br, 1'b1);
        train("branch train taken", br, 1'b1);
        flush_to(32'h1c00_2000, 1'b0);
        expect_stream("branch taken", 32'h1c00_2000, 8);
        train("branch train not taken", br, 1'b0);
        train("branch train not taken", br, 1'b0);
        flush_to(32'h1c00_2000, 1'b0);
        expect_stream("branch retrained", 32'h1c00_2000, 8);
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n       = 1'b0;
        icache_stall = 1'b0;
        resp_valid   = 1'b0;
        resp_pc      = '0;
        resp_inst[0] = '0;
        resp_inst[1] = '0;
        flush        = 1'b0;
        new_pc       = '0;
        pause        = 1'b0;
        send_en      = 1'b1;
        upd_valid    = 1'b0;
        upd_pc       = '0;
        upd_taken    = 1'b0;
        stall_en     = 1'b0;
        for (int i = 0; i < `FE_CNT_ENTRIES; i++) begin
            ref_cnt[i] = WEAK_NT;
        end
        // Jump in slot 0, jump in slot 1, backward jump
        prog[32'h1c00_1000] = encode(OP_JUMP, 32'h1c00_1000, 32'h1c00_1040);
        prog[32'h1c00_1044] = encode(OP_JUMP, 32'h1c00_1044, 32'h1c00_1104);
        prog[32'h1c00_1104] = encode(OP_JUMP, 32'h1c00_1104, 32'h1c00_1080);
        prog[32'h1c00_2004] = encode(OP_BRANCH, 32'h1c00_2004, 32'h1c00_2040);
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // First cycle out of reset
        @(negedge clk);
        check_addr("reset", `FE_RESET_PC, fetch_pc);
        if (fetch_req || out_valid[0]) begin
            abort_run("fetch request or output valid in the first cycle after reset");
        end

        expect_stream("straight", `FE_RESET_PC, 24);
        flush_to(32'h1c00_1000, 1'b0);
        expect_stream("jump", 32'h1c00_1000, 20);
        branch_training_test();
        flush_test();
        backpressure_test();

        $display("Test OK");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
source/fetch_pkg.sv
source/predict_pkg.sv
source/pc_gen.sv
source/branch_predictor.sv
source/inst_buffer.sv
source/frontend_top.sv
bench/tb_frontend.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_frontend
SEED      ?= 41471
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP SEED FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
